/* control_consts.svh */
/*
 * Player-control constants
 * Loader indices, DIP file size, spinner steps and Kroozr stick values
 */
`ifndef CONTROL_CONSTS_SVH
`define CONTROL_CONSTS_SVH

// Loader index of the game-select byte
`define IDX_GAME 8'd1
// Loader index of the DIP switch bytes
`define IDX_DIP 8'd254

// Number of DIP switch bytes
`define DIP_COUNT 8

// Spinner steps per frame
`define STEP_DIAL 12
`define STEP_TIGER 25
`define STEP_BALL 10

// Kroozr analog stick, centered value and full deflection
`define STICK_CENTER 8'd100
`define STICK_OFFSET 8'd63

`endif

/* game_pkg.sv */
/*
 * Game description types
 * Game identity, input port byte and screen orientation
 */
package game_pkg;

	// Loader byte values 0 to 5 select the games in this order
	typedef enum logic [2:0] {
		game_shollow  = 3'd0,
		game_tron     = 3'd1,
		game_twotiger = 3'd2,
		game_wacko    = 3'd3,
		game_kroozr   = 3'd4,
		game_domino   = 3'd5,
		game_none     = 3'd7
	} game_t;

	// One input port or DIP switch byte
	typedef logic [7:0] port_byte_t;

	// Bit 0 rotated, bit 1 counter-clockwise
	typedef logic [1:0] orient_t;

endpackage

/* host_pkg.sv */
/*
 * Host-side word types
 * Joystick word with its bit positions, knob report and loader address
 */
package host_pkg;

	typedef logic [31:0] joy_t;
	// Bit 8 toggles per report, bits 7..0 are a signed delta
	typedef logic [8:0] spin_report_t;
	typedef logic [24:0] ioctl_addr_t;

	// Joystick word bit positions
	localparam int jb_right = 0, jb_left = 1, jb_down = 2, jb_up = 3;
	localparam int jb_fire_a = 4, jb_fire_b = 5, jb_fire_c = 6, jb_fire_d = 7;
	localparam int jb_rot_cw = 8, jb_rot_ccw = 9;
	localparam int jb_start1 = 10, jb_start2 = 11, jb_coin = 12;
	localparam int jb_knob_ccw = 30, jb_knob_cw = 31;

endpackage

/* setup_loader.sv */
/*
 * Setup loader
 * Captures the game-select byte and the DIP switch bytes written by the
 * host loader, and decodes the selected game
 */
`timescale 1ns/1ps
`include "control_consts.svh"

module setup_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ioctl_wr,
	input  logic [7:0]            ioctl_index,
	input  host_pkg::ioctl_addr_t ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	output game_pkg::game_t       game,
	output game_pkg::port_byte_t  dip_0,
	output logic                  service
);
	import game_pkg::*;

	localparam int dip_aw = $clog2(`DIP_COUNT);

	logic [7:0] game_byte;
	port_byte_t dip_file [`DIP_COUNT];

	// ==============================
	// Game select, stored then decoded
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_byte <= 8'd0;
			game <= game_shollow;
		end else begin
			if (ioctl_wr && ioctl_index == `IDX_GAME) begin
				game_byte <= ioctl_dout;
			end
			case (game_byte)
				8'd0: game <= game_shollow;
				8'd1: game <= game_tron;
				8'd2: game <= game_twotiger;
				8'd3: game <= game_wacko;
				8'd4: game <= game_kroozr;
				8'd5: game <= game_domino;
				default: game <= game_none;
			endcase
		end
	end

	// ==============================
	// DIP switch file
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < `DIP_COUNT; i++) begin
				dip_file[i] <= 8'h00;
			end
		end else if (ioctl_wr && ioctl_index == `IDX_DIP && ioctl_addr < `DIP_COUNT) begin
			dip_file[ioctl_addr[dip_aw-1:0]] <= ioctl_dout;
		end
	end

	assign dip_0 = dip_file[0];
	// Service switch lives in the second DIP byte
	assign service = dip_file[1][0];

	// Mapper only knows the six games and the idle value
	a_game_legal: assert property (@(posedge clk_sys) disable iff (reset)
		game inside {game_shollow, game_tron, game_twotiger, game_wacko,
			game_kroozr, game_domino, game_none});

endmodule

/* spinner.sv */
/*
 * Spinner
 * Frame-strobed 8-bit position counter, stepped by buttons and
 * optionally moved by a host knob report
 */
`timescale 1ns/1ps

module spinner #(
	parameter int STEP = 12,
	parameter bit HAS_KNOB = 1'b1
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   plus,
	input  logic                   minus,
	input  logic                   strobe,
	input  host_pkg::spin_report_t spin_in,
	output logic [7:0]             spin_out
);
	localparam logic [7:0] step_b = 8'(STEP);

	logic       strobe_q;
	logic       strobe_qq;
	logic       rise;
	logic       knob_hit;
	logic [7:0] knob_delta;
	logic [7:0] step_delta;

	// Rising edge of the frame strobe, one cycle behind the sampled edge
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_q <= 1'b0;
			strobe_qq <= 1'b0;
		end else begin
			strobe_q <= strobe;
			strobe_qq <= strobe_q;
		end
	end
	assign rise = strobe_q & ~strobe_qq;

	if (HAS_KNOB) begin : g_knob
		logic knob_q;
		always_ff @(posedge clk_sys) begin
			knob_q <= spin_in[8];
		end
		// New report whenever bit 8 flips, delta already 8 bits wide
		assign knob_hit = spin_in[8] ^ knob_q;
		assign knob_delta = knob_hit ? spin_in[7:0] : 8'h00;
	end else begin : g_no_knob
		assign knob_hit = 1'b0;
		assign knob_delta = 8'h00;
	end

	always_comb begin
		step_delta = 8'h00;
		if (rise && plus && !minus) begin
			step_delta = step_b;
		end else if (rise && minus && !plus) begin
			step_delta = -step_b;
		end
	end

	// Count wraps at 8 bits
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			spin_out <= 8'h00;
		end else begin
			spin_out <= spin_out + step_delta + knob_delta;
		end
	end

	a_moves_on_event: assert property (@(posedge clk_sys) disable iff (reset)
		!(rise || knob_hit) |=> $stable(spin_out));

endmodule

/* spinner_bank.sv */
/*
 * Spinner bank
 * Tracks the active host knob and holds the dial, Two Tigers angle
 * and Wacko trackball counters
 */
`timescale 1ns/1ps
`include "control_consts.svh"

module spinner_bank (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  host_pkg::joy_t         joy1,
	input  host_pkg::joy_t         joy2,
	input  host_pkg::spin_report_t sp1,
	input  host_pkg::spin_report_t sp2,
	input  logic                   vsync,
	output logic [7:0]             spin_dial,
	output logic [7:0]             spin_angle1,
	output logic [7:0]             spin_angle2,
	output logic [7:0]             spin_x,
	output logic [7:0]             spin_y
);
	import host_pkg::*;

	joy_t         joy;
	spin_report_t prev_sp1;
	spin_report_t prev_sp2;
	spin_report_t active_knob;
	logic         knob_sel;

	assign joy = joy1 | joy2;

	// ==============================
	// Active knob, last one to change
	// ==============================
	always_ff @(posedge clk_sys) begin
		prev_sp1 <= sp1;
		prev_sp2 <= sp2;
		active_knob <= knob_sel ? sp2 : sp1;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			knob_sel <= 1'b0;
		end else if (sp2 != prev_sp2) begin
			knob_sel <= 1'b1;
		end else if (sp1 != prev_sp1) begin
			knob_sel <= 1'b0;
		end
	end

	// ==============================
	// Counters
	// ==============================
	// Shared dial for Tron and Kroozr
	spinner #(.STEP(`STEP_DIAL), .HAS_KNOB(1'b1)) u_dial (
		.clk_sys(clk_sys), .reset(reset),
		.plus(joy[jb_rot_cw] | joy[jb_knob_cw]),
		.minus(joy[jb_rot_ccw] | joy[jb_knob_ccw]),
		.strobe(vsync), .spin_in(active_knob), .spin_out(spin_dial)
	);

	// Two Tigers, one turret per player
	spinner #(.STEP(`STEP_TIGER), .HAS_KNOB(1'b1)) u_angle1 (
		.clk_sys(clk_sys), .reset(reset),
		.plus(joy1[jb_rot_cw] | joy1[jb_right] | joy1[jb_knob_cw]),
		.minus(joy1[jb_rot_ccw] | joy1[jb_left] | joy1[jb_knob_ccw]),
		.strobe(vsync), .spin_in(sp1), .spin_out(spin_angle1)
	);

	spinner #(.STEP(`STEP_TIGER), .HAS_KNOB(1'b1)) u_angle2 (
		.clk_sys(clk_sys), .reset(reset),
		.plus(joy2[jb_rot_cw] | joy2[jb_right] | joy2[jb_knob_cw]),
		.minus(joy2[jb_rot_ccw] | joy2[jb_left] | joy2[jb_knob_ccw]),
		.strobe(vsync), .spin_in(sp2), .spin_out(spin_angle2)
	);

	// Wacko trackball axes
	spinner #(.STEP(`STEP_BALL), .HAS_KNOB(1'b0)) u_x (
		.clk_sys(clk_sys), .reset(reset),
		.plus(joy[jb_right]), .minus(joy[jb_left]),
		.strobe(vsync), .spin_in('0), .spin_out(spin_x)
	);

	spinner #(.STEP(`STEP_BALL), .HAS_KNOB(1'b0)) u_y (
		.clk_sys(clk_sys), .reset(reset),
		.plus(joy[jb_up]), .minus(joy[jb_down]),
		.strobe(vsync), .spin_in('0), .spin_out(spin_y)
	);

endmodule

/* input_mapper.sv */
/*
 * Input mapper
 * Builds the five active-low input port bytes and the screen
 * orientation for the selected game
 */
`timescale 1ns/1ps
`include "control_consts.svh"

module input_mapper (
	input  game_pkg::game_t      game,
	input  game_pkg::port_byte_t dip_0,
	input  logic                 service,
	input  host_pkg::joy_t       joy1,
	input  host_pkg::joy_t       joy2,
	input  logic [7:0]           spin_dial,
	input  logic [7:0]           spin_angle1,
	input  logic [7:0]           spin_angle2,
	input  logic [7:0]           spin_x,
	input  logic [7:0]           spin_y,
	output game_pkg::port_byte_t input_0,
	output game_pkg::port_byte_t input_1,
	output game_pkg::port_byte_t input_2,
	output game_pkg::port_byte_t input_3,
	output game_pkg::port_byte_t input_4,
	output game_pkg::orient_t    orientation
);
	import game_pkg::*;
	import host_pkg::*;

	joy_t       joy;
	logic       right, left, down, up;
	logic       fire_a, fire_b, fire_c, fire_d;
	logic       game_btn;
	port_byte_t cab_port;

	// Analog stick byte, full swing one way or the other
	function automatic port_byte_t stick_pos(input logic neg, input logic pos);
		port_byte_t value;
		value = `STICK_CENTER;
		if (neg) begin
			value = `STICK_CENTER - `STICK_OFFSET;
		end else if (pos) begin
			value = `STICK_CENTER + `STICK_OFFSET;
		end
		return value;
	endfunction

	assign joy = joy1 | joy2;
	assign {up, down, left, right} = joy[jb_up:jb_right];
	assign {fire_d, fire_c, fire_b, fire_a} = joy[jb_fire_d:jb_fire_a];

	always_comb begin
		case (game)
			game_tron, game_kroozr, game_domino: game_btn = fire_a;
			game_twotiger: game_btn = fire_c;
			default: game_btn = 1'b0;
		endcase
	end

	// Cabinet port, tilt never asserted
	assign cab_port = ~{service, 1'b0, 1'b0, game_btn,
		joy[jb_start2], joy[jb_start1], 1'b0, joy[jb_coin]};

	// ==============================
	// Per-game layouts
	// ==============================
	always_comb begin
		input_0 = 8'hff;
		input_1 = 8'hff;
		input_2 = 8'hff;
		input_3 = dip_0;
		input_4 = 8'hff;
		orientation = 2'b00;
		case (game)
			game_shollow: begin
				input_0 = cab_port;
				input_1 = ~{2{fire_a, fire_b, right, left}};
			end
			game_tron: begin
				input_0 = cab_port;
				input_1 = ~{1'b0, spin_dial[7:1]};
				input_2 = ~{2{down, up, right, left}};
				input_3[7] = ~fire_a;
				input_4 = ~{1'b0, spin_dial[7:1]};
			end
			game_twotiger: begin
				orientation = 2'b01;
				input_0 = cab_port;
				input_1 = ~{1'b0, spin_angle1[7:1]};
				input_2 = ~{4'b0000, joy2[jb_fire_b], joy2[jb_fire_a],
					joy1[jb_fire_b], joy1[jb_fire_a]};
				input_4 = ~{1'b0, spin_angle2[7:1]};
			end
			game_wacko: begin
				orientation = 2'b01;
				input_0 = cab_port;
				input_1 = spin_x;
				input_2 = spin_y;
				input_4 = ~{2{fire_c, fire_b, fire_d, fire_a}};
			end
			game_kroozr: begin
				orientation = 2'b01;
				input_0 = cab_port;
				input_1 = ~{fire_b, spin_dial[7], 3'b111, spin_dial[6:4]};
				input_2 = stick_pos(left, right);
				input_4 = stick_pos(up, down);
			end
			game_domino: begin
				orientation = 2'b01;
				input_0 = cab_port;
				input_1 = ~{4'b0000, down, up, right, left};
				input_2 = ~{3'b000, fire_a, down, up, right, left};
			end
			default: begin
				// No game selected, ports stay idle
			end
		endcase
	end

endmodule

/* control_top.sv */
/*
 * Player-control top level
 * Loader, spinner bank and input mapper of the arcade board wrapper
 */
`timescale 1ns/1ps

module control_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ioctl_wr,
	input  logic [7:0]             ioctl_index,
	input  host_pkg::ioctl_addr_t  ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	input  host_pkg::joy_t         joy1,
	input  host_pkg::joy_t         joy2,
	input  host_pkg::spin_report_t sp1,
	input  host_pkg::spin_report_t sp2,
	input  logic                   vsync,
	output game_pkg::port_byte_t   input_0,
	output game_pkg::port_byte_t   input_1,
	output game_pkg::port_byte_t   input_2,
	output game_pkg::port_byte_t   input_3,
	output game_pkg::port_byte_t   input_4,
	output game_pkg::orient_t      orientation
);
	import game_pkg::*;

	game_t      game;
	port_byte_t dip_0;
	logic       service;
	logic [7:0] spin_dial, spin_angle1, spin_angle2, spin_x, spin_y;

	setup_loader u_loader (
		.clk_sys(clk_sys), .reset(reset), .ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.game(game), .dip_0(dip_0), .service(service)
	);

	spinner_bank u_spinners (
		.clk_sys(clk_sys), .reset(reset), .joy1(joy1), .joy2(joy2),
		.sp1(sp1), .sp2(sp2), .vsync(vsync), .spin_dial(spin_dial),
		.spin_angle1(spin_angle1), .spin_angle2(spin_angle2),
		.spin_x(spin_x), .spin_y(spin_y)
	);

	input_mapper u_mapper (
		.game(game), .dip_0(dip_0), .service(service), .joy1(joy1), .joy2(joy2),
		.spin_dial(spin_dial), .spin_angle1(spin_angle1), .spin_angle2(spin_angle2),
		.spin_x(spin_x), .spin_y(spin_y), .input_0(input_0), .input_1(input_1),
		.input_2(input_2), .input_3(input_3), .input_4(input_4),
		.orientation(orientation)
	);

endmodule

/* tb_control_top.sv */
/*
 * Player-control testbench
 * Reads stimulus and expected port values from control_input.txt and
 * checks the input ports and orientation of the control top level
 */
`timescale 1ns/1ps
`include "control_consts.svh"

module tb_control_top;
	import game_pkg::*;
	import host_pkg::*;

	localparam int max_steps = 64;
	// Game, dip0, dip1, joy1, joy2, vsyncs, sp1, sp2, five ports, orientation
	localparam int fields = 14;

	logic         clk_sys;
	logic         reset;
	logic         ioctl_wr;
	logic [7:0]   ioctl_index;
	ioctl_addr_t  ioctl_addr;
	logic [7:0]   ioctl_dout;
	joy_t         joy1;
	joy_t         joy2;
	spin_report_t sp1;
	spin_report_t sp2;
	logic         vsync;
	port_byte_t   input_0, input_1, input_2, input_3, input_4;
	orient_t      orientation;

	logic [31:0] vec_mem [0:max_steps*fields-1];
	int          num_steps;
	int          checks;
	int          errors;
	logic        loaded;

	control_top uut (
		.clk_sys(clk_sys), .reset(reset), .ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.joy1(joy1), .joy2(joy2), .sp1(sp1), .sp2(sp2), .vsync(vsync),
		.input_0(input_0), .input_1(input_1), .input_2(input_2),
		.input_3(input_3), .input_4(input_4), .orientation(orientation)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==============================
	// Helpers
	// ==============================
	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic loader_write(input logic [7:0] index, input ioctl_addr_t addr,
		input logic [7:0] data);
		ioctl_wr = 1'b1;
		ioctl_index = index;
		ioctl_addr = addr;
		ioctl_dout = data;
		next_cycle();
		ioctl_wr = 1'b0;
		next_cycle();
	endtask

	task automatic frame_pulse();
		vsync = 1'b1;
		repeat (3) next_cycle();
		vsync = 1'b0;
		repeat (3) next_cycle();
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
		input logic [7:0] expected, input int step);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("Error: %s got %h, expected %h at step %0d", name, got, expected, step);
		end
	endtask

	task automatic run_step(input int step);
		int base;
		base = (step - 1) * fields;
		loader_write(`IDX_GAME, 25'd0, vec_mem[base][7:0]);
		loader_write(`IDX_DIP, 25'd0, vec_mem[base+1][7:0]);
		loader_write(`IDX_DIP, 25'd1, vec_mem[base+2][7:0]);
		joy1 = vec_mem[base+3];
		joy2 = vec_mem[base+4];
		repeat (vec_mem[base+5]) frame_pulse();
		sp1 = vec_mem[base+6][8:0];
		sp2 = vec_mem[base+7][8:0];
		repeat (4) next_cycle();
		check_byte("input_0", input_0, vec_mem[base+8][7:0], step);
		check_byte("input_1", input_1, vec_mem[base+9][7:0], step);
		check_byte("input_2", input_2, vec_mem[base+10][7:0], step);
		check_byte("input_3", input_3, vec_mem[base+11][7:0], step);
		check_byte("input_4", input_4, vec_mem[base+12][7:0], step);
		check_byte("orientation", {6'b0, orientation}, vec_mem[base+13][7:0], step);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		reset = 1'b1;
		ioctl_wr = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = '0;
		ioctl_dout = 8'h00;
		joy1 = '0;
		joy2 = '0;
		sp1 = '0;
		sp2 = '0;
		vsync = 1'b0;
		checks = 0;
		errors = 0;
		loaded = 1'b0;

		// Unused words hold a value that no game byte can take
		for (int i = 0; i < max_steps * fields; i++) begin
			vec_mem[i] = 32'hf000_0000 | i;
		end
		$readmemh("control_input.txt", vec_mem);
		num_steps = 0;
		while (num_steps < max_steps && vec_mem[num_steps*fields] <= 32'hff) begin
			num_steps++;
		end
		if (num_steps == 0) begin
			errors++;
			$display("No stimulus steps were read from control_input.txt");
		end
		loaded = 1'b1;

		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		next_cycle();

		// Idle shollow layout straight out of reset
		check_byte("input_0", input_0, 8'hff, 0);
		check_byte("input_1", input_1, 8'hff, 0);
		check_byte("input_2", input_2, 8'hff, 0);
		check_byte("input_3", input_3, 8'h00, 0);
		check_byte("input_4", input_4, 8'hff, 0);
		check_byte("orientation", {6'b0, orientation}, 8'h00, 0);

		for (int s = 1; s <= num_steps; s++) begin
			run_step(s);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog sized from the number of steps
	initial begin
		wait (loaded);
		repeat (num_steps * 200 + 100) @(posedge clk_sys);
		$display("Timeout: the stimulus did not finish within %0d cycles",
			num_steps * 200 + 100);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* control_input.txt */
// game dip0 dip1 joy1 joy2 vsyncs sp1 sp2 exp_input_0 exp_input_1 exp_input_2 exp_input_3 exp_input_4 exp_orient
// Spinner counts and knob reports carry over from one line to the next
00 00 00 00000000 00000000 0 000 000 ff ff ff 00 ff 0
01 00 00 00000000 00000000 0 000 000 ff ff ff 80 ff 0
02 00 00 00000000 00000000 0 000 000 ff ff ff 00 ff 1
03 00 00 00000000 00000000 0 000 000 ff 00 00 00 ff 1
04 00 00 00000000 00000000 0 000 000 ff c7 64 00 64 1
05 00 00 00000000 00000000 0 000 000 ff ff ff 00 ff 1
06 00 00 00000000 00000000 0 000 000 ff ff ff 00 ff 0
00 5a 00 00000000 00000000 0 000 000 ff ff ff 5a ff 0
01 a5 00 00000010 00000000 0 000 000 ef ff ff 25 ff 0
01 5a 00 00000000 00000000 0 000 000 ff ff ff da ff 0
03 3c 01 00000000 00000000 0 000 000 7f 00 00 3c ff 1
00 00 00 00000011 00001800 0 000 000 f6 55 ff 00 ff 0
05 81 00 0000041a 00000000 0 000 000 eb fa ea 81 ff 1
02 42 00 00000010 00000060 0 000 000 ef ff f6 42 ff 1
03 c3 00 00000090 00000040 0 000 000 ff 00 00 c3 44 1
04 7e 00 0000000a 00000000 0 000 000 ff c7 25 7e 25 1
04 00 00 00000000 00000005 0 000 000 ff c7 a3 00 a3 1
04 00 00 00000000 00000020 0 000 000 ff 47 64 00 64 1
01 00 00 00000100 00000000 3 000 000 ff ed ff 80 ed 0
01 00 00 00000100 00000000 5 000 000 ff cf ff 80 cf 0
01 00 00 00000000 00000200 2 000 000 ff db ff 80 db 0
03 00 00 00000001 00000000 4 000 000 ff 28 00 00 ff 1
03 00 00 00000000 0000000a 3 000 000 ff 0a 1e 00 ff 1
03 00 00 00000001 00000002 2 000 000 ff 0a 1e 00 ff 1
04 00 00 00000000 00000000 0 000 000 ff c3 64 00 64 1
01 00 00 00000000 00000000 0 000 105 ff d9 ff 80 d9 0
02 00 00 00000000 00000000 0 10a 105 ff cb ff 00 d4 1
02 00 00 00000000 00000000 0 10a 0fe ff cb ff 00 d5 1
01 00 00 00000000 00000000 0 10a 0fe ff da ff 80 da 0

/* control.f */
+incdir+.
game_pkg.sv
host_pkg.sv
setup_loader.sv
spinner.sv
spinner_bank.sv
input_mapper.sv
control_top.sv
tb_control_top.sv
